// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
  --top-module epu_tb -o epu_sim &&
./obj_dir/epu_sim | tee /dev/stderr | grep -qx "TEST PASS" &&
echo "Simulation passed." ||
{ echo "Simulation failed."; exit 1; }

// File: sim/epu_checker.sv
`timescale 1ns/1ps

module epu_checker (
  input logic clk,
  input logic rst,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic busy_i,
  input logic done_i
);

  int unsigned fail_count = 0;

  ack_needs_req: assert property (@(posedge clk) disable iff (rst) ack_i |-> (cyc_i && stb_i))
    else begin
      $error("ack is high without cyc and stb");
      fail_count++;
    end

  // The slave acknowledges each request for one cycle only.
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
    else begin
      $error("ack stayed high for two cycles");
      fail_count++;
    end

  busy_not_done: assert property (@(posedge clk) disable iff (rst) !(busy_i && done_i))
    else begin
      $error("busy and done are high together");
      fail_count++;
    end

endmodule

bind epu_top epu_checker u_checker (
  .clk   (clk),
  .rst   (rst),
  .cyc_i (wb_cyc_i),
  .stb_i (wb_stb_i),
  .ack_i (wb_ack_o),
  .busy_i(busy),
  .done_i(done)
);

// File: sim/epu_clkgen.sv
`timescale 1ns/1ps

module epu_clkgen #(
  parameter real PERIOD = 40.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

// File: sim/epu_stim.txt
# name  length  activation_value  weight_value
# A value of -1 fills that buffer with random data; any other value fills every element.
full_random   64  -1      -1
neg_act       24  -5      7
neg_both      20  -300    -9
max_pos        8  32767   127
min_both      12  -32768  -128
min_max       16  -32768  127
max_min       10  32767   -128
short_random   5  -1      -1
single         1  -1      3
mid_random    40  -1      -1

// File: sim/epu_tb.sv
`timescale 1ns/1ps

module epu_tb;

  localparam int DEPTH      = epu_pkg::DEPTH_DEF;
  localparam int AW         = epu_pkg::AW_DEF;
  localparam int ACK_LIMIT  = 20;
  localparam int POLL_LIMIT = 200;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [11:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  int          seed = 92786;

  // Reference copies of the buffers.
  epu_pkg::act_t act_mem [DEPTH];
  epu_pkg::wgt_t wgt_mem [DEPTH];
  epu_pkg::res_t out_model [DEPTH];
  logic          out_known [DEPTH];

  epu_clkgen #(.PERIOD(40.0)) u_clkgen (.clk_o(clk));

  epu_top #(.DEPTH(DEPTH), .AW(AW)) UUT (
    .clk(clk), .rst(rst),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
    .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r)
  );

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  always @(negedge clk) begin
    if (UUT.u_checker.fail_count != 0) begin
      $display("A bus or engine assertion failed.");
      abort_run();
    end
  end

  function automatic logic [11:0] word_addr(input logic [1:0] region, input int offset);
    return {region, offset[9:0]};
  endfunction

  // The strobe stays up through the ack cycle, where the slave ignores it.
  task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(negedge clk);
    while (!wb_ack) begin
      waited++;
      if (waited >= ACK_LIMIT) begin
        $display("No acknowledge came for the bus access at address 0x%03h.", adr);
        abort_run();
      end
      @(negedge clk);
    end
    rdat = wb_dat_r;
    @(negedge clk);
    if (wb_ack) begin
      $display("The bus access at address 0x%03h was acknowledged twice.", adr);
      abort_run();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    bus_cycle(1'b1, adr, data, ignored);
  endtask

  task automatic wb_read(input logic [11:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  task automatic wait_done(input string name);
    logic [31:0] stat;
    int polls;
    polls = 0;
    wb_read(word_addr(epu_pkg::REG_REGION, epu_pkg::CTRL_ADDR), stat);
    while (!stat[epu_pkg::STAT_DONE]) begin
      polls++;
      if (polls >= POLL_LIMIT) begin
        $display("Test %s: the engine never reported done.", name);
        abort_run();
      end
      wb_read(word_addr(epu_pkg::REG_REGION, epu_pkg::CTRL_ADDR), stat);
    end
  endtask

  task automatic check_res(input string name, input string what, input epu_pkg::res_t exp,
                           input logic [31:0] act);
    if (act !== {8'h00, exp}) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_stat(input string name, input string what, input logic busy,
                            input logic done, input logic [31:0] act);
    logic [31:0] exp;
    exp = '0;
    exp[epu_pkg::STAT_BUSY] = busy;
    exp[epu_pkg::STAT_DONE] = done;
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
      abort_run();
    end
  endtask

  // Buffer words come back sign-extended to the full bus width.
  task automatic check_word(input string name, input string what, input epu_pkg::act_t exp,
                            input logic [31:0] act);
    if (act !== {{16{exp[15]}}, exp}) begin
      $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", name, what,
               {{16{exp[15]}}, exp}, act);
      abort_run();
    end
  endtask

  task automatic run_test(input string name, input int len, input int act_val,
                          input int wgt_val, input logic done_before);
    logic [31:0] rd;
    int prod;
    for (int i = 0; i < len; i++) begin
      act_mem[i] = (act_val == -1) ? epu_pkg::act_t'($random(seed)) : epu_pkg::act_t'(act_val);
      wgt_mem[i] = (wgt_val == -1) ? epu_pkg::wgt_t'($random(seed)) : epu_pkg::wgt_t'(wgt_val);
      wb_write(word_addr(epu_pkg::IN_REGION, i), 32'(act_mem[i]));
      wb_write(word_addr(epu_pkg::WGT_REGION, i), 32'(wgt_mem[i]));
      prod = int'(act_mem[i]) * int'(wgt_mem[i]);
      out_model[i] = (prod < 0) ? '0 : epu_pkg::res_t'(prod);
      out_known[i] = 1'b1;
    end
    wb_write(word_addr(epu_pkg::REG_REGION, epu_pkg::LEN_ADDR), 32'(len));
    wb_read(word_addr(epu_pkg::REG_REGION, epu_pkg::CTRL_ADDR), rd);
    check_stat(name, "status before start", 1'b0, done_before, rd);
    wb_write(word_addr(epu_pkg::REG_REGION, epu_pkg::CTRL_ADDR), 32'h1);
    wb_read(word_addr(epu_pkg::REG_REGION, epu_pkg::CTRL_ADDR), rd);
    check_stat(name, "status after start", 1'b1, 1'b0, rd);
    // Long runs leave room for host accesses while the engine owns the buffers.
    if (len >= 16) begin
      wb_write(word_addr(epu_pkg::IN_REGION, 0), 32'(~act_mem[0]));
      wb_read(word_addr(epu_pkg::IN_REGION, 0), rd);
      check_word(name, "in[0] read while busy", '0, rd);
    end
    wait_done(name);
    wb_read(word_addr(epu_pkg::REG_REGION, epu_pkg::CTRL_ADDR), rd);
    check_stat(name, "status after run", 1'b0, 1'b1, rd);
    for (int i = 0; i < DEPTH; i++) begin
      if (out_known[i]) begin
        wb_read(word_addr(epu_pkg::OUT_REGION, i), rd);
        check_res(name, $sformatf("out[%0d]", i), out_model[i], rd);
      end
    end
    for (int i = 0; i < len; i++) begin
      wb_read(word_addr(epu_pkg::IN_REGION, i), rd);
      check_word(name, $sformatf("in[%0d]", i), act_mem[i], rd);
      wb_read(word_addr(epu_pkg::WGT_REGION, i), rd);
      check_word(name, $sformatf("wgt[%0d]", i), epu_pkg::act_t'(wgt_mem[i]), rd);
    end
  endtask

  initial begin
    string           line;
    logic [8*24-1:0] tname;
    int              len;
    int              act_val;
    int              wgt_val;
    int              fd;
    int              tests;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    tests    = 0;
    for (int i = 0; i < DEPTH; i++) begin
      out_known[i] = 1'b0;
    end
    fd = $fopen("sim/epu_stim.txt", "r");
    if (fd == 0) begin
      $display("The stimulus file sim/epu_stim.txt could not be opened.");
      abort_run();
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%s %d %d %d", tname, len, act_val, wgt_val) != 4) begin
          $display("A stimulus line could not be parsed: %s", line);
          abort_run();
        end
        run_test($sformatf("%0s", tname), len, act_val, wgt_val, tests > 0);
        tests++;
      end
    end
    $fclose(fd);
    if (tests > 0 && UUT.u_checker.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("No test ran, or a bus or engine assertion failed.");
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: source/epu_buf_wrapper.sv
`timescale 1ns/1ps

module epu_buf_wrapper #(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = epu_pkg::DEPTH_DEF,
  parameter int  AW     = epu_pkg::AW_DEF
) (
  input  logic          clk,
  input  logic          rst,
  // Host side, from the bus slave.
  input  logic          host_sel_i,
  input  logic          host_we_i,
  input  logic [AW-1:0] host_addr_i,
  input  word_t         host_wdata_i,
  output word_t         host_rdata_o,
  // Engine side.
  input  logic          eng_busy_i,
  input  logic          eng_cs_i,
  input  logic          eng_we_i,
  input  logic [AW-1:0] eng_addr_i,
  input  word_t         eng_wdata_i,
  output word_t         eng_rdata_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ENGINE  = 2'd1,
    HOST_RD = 2'd2,
    HOST_WR = 2'd3
  } state_t;

  state_t        state;
  state_t        state_nxt;
  logic          sram_cs;
  logic          sram_we;
  logic [AW-1:0] sram_addr;
  word_t         sram_wdata;
  word_t         sram_rdata;

  epu_sram #(
    .word_t(word_t),
    .DEPTH (DEPTH),
    .AW    (AW)
  ) u_sram (
    .clk    (clk),
    .cs_i   (sram_cs),
    .we_i   (sram_we),
    .addr_i (sram_addr),
    .wdata_i(sram_wdata),
    .rdata_o(sram_rdata)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Host accesses last a single cycle, so every state returns to the same decision.
  always_comb begin
    state_nxt = IDLE;
    if (eng_busy_i) begin
      state_nxt = ENGINE;
    end else if (host_sel_i) begin
      state_nxt = host_we_i ? HOST_WR : HOST_RD;
    end
  end

  // The engine owns the array as soon as busy rises; host requests are dropped then.
  always_comb begin
    sram_cs    = 1'b0;
    sram_we    = 1'b0;
    sram_addr  = host_addr_i;
    sram_wdata = host_wdata_i;
    if (eng_busy_i) begin
      sram_cs    = eng_cs_i;
      sram_we    = eng_we_i;
      sram_addr  = eng_addr_i;
      sram_wdata = eng_wdata_i;
    end else if (host_sel_i) begin
      sram_cs = 1'b1;
      sram_we = host_we_i;
    end
  end

  // HOST_RD is the ack cycle of a host read.
  assign host_rdata_o = (state == HOST_RD) ? sram_rdata : '0;
  assign eng_rdata_o  = (state == ENGINE) ? sram_rdata : '0;

endmodule

// File: source/epu_mac_engine.sv
`timescale 1ns/1ps

module epu_mac_engine #(
  parameter int DEPTH = epu_pkg::DEPTH_DEF,
  parameter int AW    = epu_pkg::AW_DEF
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          start_i,
  input  logic [AW:0]   len_i,
  input  epu_pkg::act_t in_rdata_i,
  input  epu_pkg::wgt_t wgt_rdata_i,
  output logic          busy_o,
  output logic          done_o,
  output logic          rd_cs_o,
  output logic [AW-1:0] rd_addr_o,
  output logic          wr_we_o,
  output logic [AW-1:0] wr_addr_o,
  output epu_pkg::res_t wr_data_o
);

  logic          busy_q;
  logic          done_q;
  logic          start_ok;
  logic [AW:0]   len_q;
  logic [AW-1:0] cnt;
  logic          rd_active;
  logic          last_rd;
  logic          s1_valid;
  logic          s2_valid;
  logic [AW-1:0] s1_addr;
  logic [AW-1:0] s2_addr;
  epu_pkg::res_t prod_q;

  assign start_ok = start_i & ~busy_q;
  assign last_rd  = rd_active & ({1'b0, cnt} == len_q - 1'b1);

  // Stage 1 issues addresses, stage 2 holds read data, stage 3 holds the product.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      len_q     <= '0;
      cnt       <= '0;
      rd_active <= 1'b0;
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
    end else begin
      s1_valid <= rd_active;
      s2_valid <= s1_valid;
      if (start_ok) begin
        busy_q    <= 1'b1;
        done_q    <= 1'b0;
        rd_active <= 1'b1;
        cnt       <= '0;
        // A length of zero or beyond the buffer runs the whole buffer.
        len_q     <= (len_i == '0 || len_i > DEPTH) ? (AW+1)'(DEPTH) : len_i;
      end else begin
        if (rd_active) begin
          cnt <= cnt + 1'b1;
          if (last_rd) begin
            rd_active <= 1'b0;
          end
        end
        // The last write is in flight when only stage 3 is still valid.
        if (busy_q && s2_valid && !s1_valid && !rd_active) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    s1_addr <= cnt;
    s2_addr <= s1_addr;
    prod_q  <= epu_pkg::res_t'(in_rdata_i) * epu_pkg::res_t'(wgt_rdata_i);
  end

  assign busy_o    = busy_q;
  assign done_o    = done_q;
  assign rd_cs_o   = rd_active;
  assign rd_addr_o = cnt;
  assign wr_we_o   = s2_valid;
  assign wr_addr_o = s2_addr;
  // ReLU.
  assign wr_data_o = (prod_q < 0) ? '0 : prod_q;

endmodule

// File: source/epu_pkg.sv
package epu_pkg;

  // Data words of the three buffers.
  typedef logic signed [15:0] act_t;
  typedef logic signed [7:0]  wgt_t;
  typedef logic signed [23:0] res_t;

  // Region codes, taken from word address bits 11:10.
  parameter logic [1:0] REG_REGION = 2'd0;
  parameter logic [1:0] IN_REGION  = 2'd1;
  parameter logic [1:0] WGT_REGION = 2'd2;
  parameter logic [1:0] OUT_REGION = 2'd3;

  // Word offsets inside the register region.
  parameter int CTRL_ADDR = 0;
  parameter int LEN_ADDR  = 1;

  // Bit positions in the status word.
  parameter int STAT_BUSY = 0;
  parameter int STAT_DONE = 1;

  // Default buffer geometry.
  parameter int DEPTH_DEF = 64;
  parameter int AW_DEF    = 6;

endpackage

// File: source/epu_sram.sv
`timescale 1ns/1ps

module epu_sram #(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = epu_pkg::DEPTH_DEF,
  parameter int  AW     = epu_pkg::AW_DEF
) (
  input  logic          clk,
  input  logic          cs_i,
  input  logic          we_i,
  input  logic [AW-1:0] addr_i,
  input  word_t         wdata_i,
  output word_t         rdata_o
);

  word_t mem [DEPTH];

  // Read data appears one cycle after a selected read and holds otherwise.
  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: source/epu_top.sv
`timescale 1ns/1ps

module epu_top #(
  parameter int DEPTH = epu_pkg::DEPTH_DEF,
  parameter int AW    = epu_pkg::AW_DEF
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [11:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o
);

  logic          in_sel;
  logic          wgt_sel;
  logic          out_sel;
  logic          host_we;
  logic [AW-1:0] host_addr;
  logic [31:0]   host_wdata;
  logic          start;
  logic [AW:0]   len;
  logic          busy;
  logic          done;
  logic          rd_cs;
  logic [AW-1:0] rd_addr;
  logic          wr_we;
  logic [AW-1:0] wr_addr;
  epu_pkg::res_t wr_data;
  epu_pkg::act_t in_host_rdata;
  epu_pkg::wgt_t wgt_host_rdata;
  epu_pkg::res_t out_host_rdata;
  epu_pkg::act_t in_eng_rdata;
  epu_pkg::wgt_t wgt_eng_rdata;

  epu_wb_slave #(.AW(AW)) u_slave (
    .clk(clk), .rst(rst),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
    .busy_i(busy), .done_i(done),
    .in_rdata_i(in_host_rdata), .wgt_rdata_i(wgt_host_rdata), .out_rdata_i(out_host_rdata),
    .in_sel_o(in_sel), .wgt_sel_o(wgt_sel), .out_sel_o(out_sel),
    .host_we_o(host_we), .host_addr_o(host_addr), .host_wdata_o(host_wdata),
    .start_o(start), .len_o(len)
  );

  epu_mac_engine #(.DEPTH(DEPTH), .AW(AW)) u_engine (
    .clk(clk), .rst(rst),
    .start_i(start), .len_i(len),
    .in_rdata_i(in_eng_rdata), .wgt_rdata_i(wgt_eng_rdata),
    .busy_o(busy), .done_o(done),
    .rd_cs_o(rd_cs), .rd_addr_o(rd_addr),
    .wr_we_o(wr_we), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
  );

  // The input and weight buffers are read side by side with one address.
  epu_buf_wrapper #(.word_t(epu_pkg::act_t), .DEPTH(DEPTH), .AW(AW)) u_in_buf (
    .clk(clk), .rst(rst),
    .host_sel_i(in_sel), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_wdata_i(host_wdata[15:0]), .host_rdata_o(in_host_rdata),
    .eng_busy_i(busy), .eng_cs_i(rd_cs), .eng_we_i(1'b0), .eng_addr_i(rd_addr),
    .eng_wdata_i('0), .eng_rdata_o(in_eng_rdata)
  );

  epu_buf_wrapper #(.word_t(epu_pkg::wgt_t), .DEPTH(DEPTH), .AW(AW)) u_wgt_buf (
    .clk(clk), .rst(rst),
    .host_sel_i(wgt_sel), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_wdata_i(host_wdata[7:0]), .host_rdata_o(wgt_host_rdata),
    .eng_busy_i(busy), .eng_cs_i(rd_cs), .eng_we_i(1'b0), .eng_addr_i(rd_addr),
    .eng_wdata_i('0), .eng_rdata_o(wgt_eng_rdata)
  );

  // The host can only read the output buffer.
  epu_buf_wrapper #(.word_t(epu_pkg::res_t), .DEPTH(DEPTH), .AW(AW)) u_out_buf (
    .clk(clk), .rst(rst),
    .host_sel_i(out_sel), .host_we_i(1'b0), .host_addr_i(host_addr),
    .host_wdata_i('0), .host_rdata_o(out_host_rdata),
    .eng_busy_i(busy), .eng_cs_i(wr_we), .eng_we_i(wr_we), .eng_addr_i(wr_addr),
    .eng_wdata_i(wr_data), .eng_rdata_o()
  );

endmodule

// File: source/epu_wb_slave.sv
`timescale 1ns/1ps

module epu_wb_slave #(
  parameter int AW = epu_pkg::AW_DEF
) (
  input  logic                clk,
  input  logic                rst,
  // Wishbone classic slave port.
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [11:0]         wb_adr_i,
  input  logic [31:0]         wb_dat_i,
  output logic                wb_ack_o,
  output logic [31:0]         wb_dat_o,
  // Engine status.
  input  logic                busy_i,
  input  logic                done_i,
  // Buffer read data.
  input  epu_pkg::act_t       in_rdata_i,
  input  epu_pkg::wgt_t       wgt_rdata_i,
  input  epu_pkg::res_t       out_rdata_i,
  // Buffer host requests.
  output logic                in_sel_o,
  output logic                wgt_sel_o,
  output logic                out_sel_o,
  output logic                host_we_o,
  output logic [AW-1:0]       host_addr_o,
  output logic [31:0]         host_wdata_o,
  // Engine control.
  output logic                start_o,
  output logic [AW:0]         len_o
);

  logic        req_new;
  logic        ack_q;
  logic [1:0]  region;
  logic [1:0]  region_q;
  logic [9:0]  offset;
  logic        reg_wr;
  logic [31:0] status;
  logic [31:0] reg_rdata_q;
  logic [AW:0] len_q;
  logic        start_q;

  // A new request is one that has not been acknowledged yet.
  assign req_new = wb_cyc_i & wb_stb_i & ~ack_q;
  assign region  = wb_adr_i[11:10];
  assign offset  = wb_adr_i[9:0];
  assign reg_wr  = req_new & wb_we_i & (region == epu_pkg::REG_REGION);

  always_comb begin
    status                     = '0;
    status[epu_pkg::STAT_BUSY] = busy_i;
    status[epu_pkg::STAT_DONE] = done_i;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      region_q <= epu_pkg::REG_REGION;
      len_q    <= '0;
    end else begin
      ack_q   <= req_new;
      start_q <= reg_wr & (offset == 10'(epu_pkg::CTRL_ADDR)) & wb_dat_i[0] & ~busy_i;
      if (req_new) begin
        region_q <= region;
      end
      if (reg_wr && offset == 10'(epu_pkg::LEN_ADDR)) begin
        len_q <= wb_dat_i[AW:0];
      end
    end
  end

  // Register reads are captured in the request cycle so data is stable through ack.
  always_ff @(posedge clk) begin
    if (req_new) begin
      reg_rdata_q <= (offset == 10'(epu_pkg::LEN_ADDR)) ? 32'(len_q) : status;
    end
  end

  always_comb begin
    wb_dat_o = '0;
    if (ack_q) begin
      case (region_q)
        epu_pkg::REG_REGION: wb_dat_o = reg_rdata_q;
        epu_pkg::IN_REGION:  wb_dat_o = 32'(in_rdata_i);
        epu_pkg::WGT_REGION: wb_dat_o = 32'(wgt_rdata_i);
        default:             wb_dat_o = 32'($unsigned(out_rdata_i));
      endcase
    end
  end

  assign wb_ack_o     = ack_q;
  assign in_sel_o     = req_new & (region == epu_pkg::IN_REGION);
  assign wgt_sel_o    = req_new & (region == epu_pkg::WGT_REGION);
  assign out_sel_o    = req_new & (region == epu_pkg::OUT_REGION);
  assign host_we_o    = wb_we_i;
  assign host_addr_o  = wb_adr_i[AW-1:0];
  assign host_wdata_o = wb_dat_i;
  assign start_o      = start_q;
  assign len_o        = len_q;

endmodule

// File: verilog.f
source/epu_pkg.sv
source/epu_sram.sv
source/epu_buf_wrapper.sv
source/epu_wb_slave.sv
source/epu_mac_engine.sv
source/epu_top.sv
sim/epu_clkgen.sv
sim/epu_checker.sv
sim/epu_tb.sv
